//--- rvSoc.f
+incdir+include
source/rvCorePkg.sv
source/instrMem.sv
source/instrDecoder.sv
source/regFile.sv
source/executeUnit.sv
source/coreControl.sv
source/rvSoc.sv
tb/tbRvSoc.sv

//--- Makefile
# Verilator build and run of the rvSoc testbench

VERILATOR  ?= verilator
TOP        := tbRvSoc
FILELIST   := rvSoc.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
PASS_TEXT  := sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tbRvSoc.sv
`timescale 1ns/10ps
`include "rvCore_cfg.svh"

module tbRvSoc
  import rvCorePkg::*;
();

  localparam int waitLimit = 600; // cycles allowed per led wait
  localparam int trapMarker = 13; // only seen if a jump falls through
  localparam int restartTarget = 25;

  logic CLK = 1'b0;
  logic resetn;
  logic progWe;
  logic [`IMEM_ADDR_WIDTH-1:0] progAddr;
  instrWord_t progData;
  ledWord_t leds;

  instrWord_t prog [$]; // index is the word address
  ledWord_t expSeq [$]; // led values expected in order
  int errorCount = 0;
  int errorsAtStart = 0;
  int testCount = 0;
  int failedTests = 0;

  always #20 CLK = ~CLK; // 40 ns period

  rvSoc dut0 (
    .CLK(CLK), .resetn(resetn), .progWe(progWe), .progAddr(progAddr),
    .progData(progData), .leds(leds)
  );

  // instruction encoders in assembly operand order
  task automatic putR(input int funct7, input int funct3, input int rd, input int rs1,
                      input int rs2);
    prog.push_back({7'(funct7), regId_t'(rs2), regId_t'(rs1), 3'(funct3), regId_t'(rd),
                    opAluReg});
  endtask

  task automatic putI(input opcode_e op, input int funct3, input int rd, input int rs1,
                      input int imm);
    prog.push_back({12'(imm), regId_t'(rs1), 3'(funct3), regId_t'(rd), op});
  endtask

  // offset in bytes from the branch itself
  task automatic putB(input int funct3, input int rs1, input int rs2, input word_t offset);
    prog.push_back({offset[12], offset[10:5], regId_t'(rs2), regId_t'(rs1), 3'(funct3),
                    offset[4:1], offset[11], opBranch});
  endtask

  task automatic putU(input opcode_e op, input int rd, input word_t value);
    prog.push_back({value[31:12], regId_t'(rd), op}); // low 12 bits dropped
  endtask

  task automatic putJ(input int rd, input word_t offset);
    prog.push_back({offset[20], offset[10:1], offset[11], offset[19:12], regId_t'(rd), opJal});
  endtask

  task automatic addi(input int rd, input int rs1, input int imm);
    putI(opAluImm, 0, rd, rs1, imm);
  endtask

  // lui rounded up so the sign extended low part lands exactly
  task automatic loadConst(input int rd, input word_t value);
    putU(opLui, rd, value + 32'h800);
    addi(rd, rd, int'(value)); // encoder keeps low 12 bits
  endtask

  // core held in reset while the words go in
  task automatic loadProgram();
    @(posedge CLK);
    resetn <= 1'b0;
    foreach (prog[i]) begin
      progWe <= 1'b1;
      progAddr <= i[`IMEM_ADDR_WIDTH-1:0];
      progData <= prog[i];
      @(posedge CLK);
    end
    progWe <= 1'b0;
    repeat (3) @(posedge CLK); // lets the fetch register see word 0
    resetn <= 1'b1;
  endtask

  // poll at the falling edge where leds are stable
  task automatic waitLeds(input ledWord_t expected, output bit reached);
    int cycles;
    reached = 1'b0;
    cycles = 0;
    while (!reached && (cycles < waitLimit)) begin
      @(negedge CLK);
      reached = (leds === expected);
      cycles++;
    end
    if (!reached) begin
      $display("timeout at %0t ns: leds stayed %h and never showed %h within %0d cycles",
               $time, leds, expected, waitLimit);
      errorCount++;
    end
  endtask

  task automatic checkLeds(input ledWord_t expected, input ledWord_t actual);
    if (actual !== expected) begin
      $display("error at %0t ns: leds expected %h actual %h", $time, expected, actual);
      errorCount++;
    end
  endtask

  // three cycles per instruction covers any straight-line tail
  task automatic settleAndCheck(input ledWord_t expected);
    repeat (3 * prog.size() + 12) @(negedge CLK);
    checkLeds(expected, leds); // halt loop reached by now
  endtask

  task automatic runProgram();
    bit reached;
    int i;
    loadProgram();
    reached = 1'b1;
    i = 0;
    while (reached && (i < expSeq.size())) begin
      waitLeds(expSeq[i], reached);
      i++;
    end
    if (reached) begin
      settleAndCheck(expSeq[expSeq.size()-1]);
    end
  endtask

  task automatic startTest();
    prog.delete();
    expSeq.delete();
    errorsAtStart = errorCount;
  endtask

  task automatic endTest(input string name);
    testCount++;
    if (errorCount == errorsAtStart) begin
      $display("test %s: ok", name);
    end else begin
      failedTests++;
      $display("test %s: FAIL with %0d errors", name, errorCount - errorsAtStart);
    end
  endtask

  // op x1 x2 x3 with the rv32i result it must give
  task automatic aluRegCase(input int funct7, input int funct3, input word_t result);
    putR(funct7, funct3, 1, 2, 3);
    expSeq.push_back(ledWord_t'(result));
  endtask

  task automatic aluImmCase(input int funct3, input int imm, input word_t result);
    putI(opAluImm, funct3, 1, 2, imm);
    expSeq.push_back(ledWord_t'(result));
  endtask

  task automatic testImmChain();
    int sum;
    int k;
    startTest();
    sum = 0;
    putR(0, 0, 1, 0, 0); // add x1 x0 x0
    expSeq.push_back(ledWord_t'(sum));
    for (int n = 0; n < 8; n++) begin
      k = int'($urandom_range(60)) - 20; // small and sometimes negative
      sum += k;
      addi(1, 1, k);
      expSeq.push_back(ledWord_t'(sum));
    end
    putJ(0, 0); // halt
    runProgram();
    endTest("immChain");
  endtask

  task automatic testRegAlu();
    word_t a;
    word_t b;
    int sh;
    startTest();
    a = $urandom() | 32'h8000_0000; // negative so sra fills ones
    b = ($urandom() & 32'hffff_ffe0) | $urandom_range(4, 1); // short shift keeps sll bits
    sh = int'($urandom_range(31, 28)); // sign fill reaches the low bits
    loadConst(2, a);
    loadConst(3, b);
    aluRegCase(32, 0, a - b); // sub
    aluRegCase(0, 4, a ^ b);
    aluRegCase(0, 6, a | b);
    aluRegCase(0, 7, a & b);
    aluRegCase(0, 2, word_t'((a[31] != b[31]) ? a[31] : (a < b))); // slt
    aluRegCase(0, 3, word_t'(a < b)); // sltu
    aluRegCase(0, 1, a << b[4:0]);
    aluRegCase(0, 5, a >> b[4:0]);
    aluRegCase(32, 5, ~(~a >> b[4:0])); // sra of a negative a
    aluImmCase(1, sh, a << sh); // slli
    aluImmCase(5, sh, a >> sh);
    aluImmCase(5, 'h400 | sh, ~(~a >> sh)); // srai has imm bit 10
    putJ(0, 0);
    runProgram();
    endTest("regAlu");
  endtask

  task automatic testBranches();
    int n1;
    int n2;
    int n3;
    int loopTop;
    startTest();
    n1 = int'($urandom_range(7, 2));
    n2 = int'($urandom_range(7, 2));
    n3 = int'($urandom_range(7, 2));
    addi(1, 0, 0);
    addi(2, 0, n1);
    loopTop = prog.size();
    addi(1, 1, 1);
    putB(1, 1, 2, (loopTop - prog.size()) * 4); // bne x1 x2 until x1 == n1
    addi(3, 0, 0);
    addi(4, 0, n2);
    loopTop = prog.size();
    addi(1, 1, 2);
    addi(3, 3, 1);
    putB(4, 3, 4, (loopTop - prog.size()) * 4); // blt x3 x4 for n2 passes
    addi(5, 0, n3);
    addi(6, 0, 1);
    loopTop = prog.size();
    addi(1, 1, 1);
    addi(5, 5, -1);
    putB(7, 5, 6, (loopTop - prog.size()) * 4); // bgeu counts x5 down to 0
    putB(0, 1, 0, 8); // beq x1 x0 never taken here
    addi(1, 1, 3);
    putJ(0, 0);
    // x1 only climbs and stays below 32
    expSeq.push_back(ledWord_t'(n1 + 2 * n2 + n3 + 3));
    runProgram();
    endTest("branches");
  endtask

  task automatic testJumps();
    word_t u;
    startTest();
    u = $urandom();
    putR(0, 0, 1, 0, 0);
    putJ(1, 8); // pc 4 links 8 and lands on pc 12
    addi(1, 0, trapMarker);
    addi(2, 1, 17); // x2 = 25 only if the trap was skipped
    putI(opJalr, 0, 1, 2, 0); // pc 16 links 20 and jumps to 24 with bit 0 cleared
    addi(1, 0, trapMarker);
    addi(1, 1, 1);
    putU(opAuipc, 1, u); // sits at pc 28
    putJ(0, 0);
    expSeq.push_back(ledWord_t'(8));
    expSeq.push_back(ledWord_t'(20));
    expSeq.push_back(ledWord_t'(21));
    expSeq.push_back(ledWord_t'(32'd28 + {u[31:12], 12'b0}));
    runProgram();
    endTest("jumps");
  endtask

  task automatic testX0AndRestart();
    bit reached;
    int loopTop;
    startTest();
    addi(1, 0, 9);
    addi(0, 0, 21); // none of these may stick in x0
    putU(opLui, 0, 32'h1234_5000);
    putR(0, 0, 0, 1, 1);
    putR(0, 0, 1, 0, 0); // x1 back to zero
    putJ(0, 0);
    expSeq.push_back(ledWord_t'(9));
    expSeq.push_back(ledWord_t'(0));
    runProgram();
    // counting loop broken by a reset halfway
    prog.delete();
    expSeq.delete();
    addi(1, 0, 0);
    addi(2, 0, restartTarget);
    loopTop = prog.size();
    addi(1, 1, 1);
    putB(1, 1, 2, (loopTop - prog.size()) * 4);
    putJ(0, 0);
    loadProgram();
    waitLeds(ledWord_t'(10), reached);
    if (reached) begin
      @(posedge CLK);
      resetn <= 1'b0;
      @(negedge CLK);
      checkLeds(ledWord_t'(0), leds); // async clear
      repeat (3) @(posedge CLK);
      resetn <= 1'b1; // same image reruns from pc 0
      waitLeds(ledWord_t'(restartTarget), reached);
      if (reached) begin
        settleAndCheck(ledWord_t'(restartTarget));
      end
    end
    endTest("x0AndRestart");
  endtask

  initial begin
    void'($urandom(32'h8b20));
    resetn <= 1'b0;
    progWe <= 1'b0;
    progAddr <= '0;
    progData <= '0;
    repeat (3) @(posedge CLK);
    resetn <= 1'b1;
    testImmChain();
    testRegAlu();
    testBranches();
    testJumps();
    testX0AndRestart();
    $display("tests %0d, failing tests %0d, errors %0d", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- source/rvSoc.sv
`timescale 1ns/10ps
`include "rvCore_cfg.svh"

module rvSoc
  import rvCorePkg::*;
(
  input  logic CLK,
  input  logic resetn,
  input  logic progWe, // program load port
  input  logic [`IMEM_ADDR_WIDTH-1:0] progAddr,
  input  instrWord_t progData,
  output ledWord_t leds
);

  instrWord_t fetchWord;
  instrWord_t instr;
  decodedInstr_t dec;
  logic [`IMEM_ADDR_WIDTH-1:0] fetchAddr;
  word_t pc;
  word_t nextPc;
  word_t wbData;
  word_t rs1Val;
  word_t rs2Val;
  logic readEn;
  logic wbEn;

  instrMem uInstrMem (
    .CLK(CLK), .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .fetchAddr(fetchAddr), .fetchWord(fetchWord)
  );

  coreControl uCoreControl (
    .CLK(CLK), .resetn(resetn), .fetchWord(fetchWord), .dec(dec),
    .nextPc(nextPc), .wbData(wbData), .fetchAddr(fetchAddr), .instr(instr),
    .pc(pc), .readEn(readEn), .wbEn(wbEn), .leds(leds)
  );

  instrDecoder uInstrDecoder (
    .instr(instr), .dec(dec)
  );

  // rd id comes straight from the held instruction
  regFile uRegFile (
    .CLK(CLK), .resetn(resetn), .readEn(readEn),
    .rs1Id(dec.rs1Id), .rs2Id(dec.rs2Id), .rdId(dec.rdId),
    .wbEn(wbEn), .wbData(wbData), .rs1Val(rs1Val), .rs2Val(rs2Val)
  );

  executeUnit uExecuteUnit (
    .dec(dec), .rs1Val(rs1Val), .rs2Val(rs2Val), .pc(pc),
    .nextPc(nextPc), .wbData(wbData)
  );

endmodule

//--- source/coreControl.sv
`timescale 1ns/10ps
`include "rvCore_cfg.svh"

module coreControl
  import rvCorePkg::*;
(
  input  logic CLK,
  input  logic resetn,
  input  instrWord_t fetchWord,
  input  decodedInstr_t dec,
  input  word_t nextPc,
  input  word_t wbData,
  output logic [`IMEM_ADDR_WIDTH-1:0] fetchAddr,
  output instrWord_t instr,
  output word_t pc,
  output logic readEn,
  output logic wbEn,
  output ledWord_t leds
);

  coreState_e state;
  logic writesRd; // opcode has an rd result

  assign writesRd = dec.isAluReg || dec.isAluImm || dec.isJal ||
                    dec.isJalr || dec.isLui || dec.isAuipc;

  // in stExecute the memory already reads the next pc
  // so the word is waiting when stFetchInstr comes round
  assign fetchAddr = (state == stExecute) ? nextPc[`IMEM_ADDR_WIDTH+1:2]
                                          : pc[`IMEM_ADDR_WIDTH+1:2];

  // sequencer, pc, strobes, leds
  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      state  <= stFetchInstr;
      pc     <= word_t'(`RESET_PC);
      readEn <= 1'b0;
      wbEn   <= 1'b0;
      leds   <= '0;
    end else begin
      readEn <= 1'b0; // both strobes last one state
      wbEn   <= 1'b0;
      case (state)
        stFetchInstr: begin
          state  <= stFetchRegs;
          readEn <= 1'b1; // operands latched on next edge
        end
        stFetchRegs: begin
          state <= stExecute;
          wbEn  <= writesRd; // level for the whole execute cycle
        end
        stExecute: begin
          state <= stFetchInstr;
          pc    <= nextPc;
        end
        default: state <= stFetchInstr;
      endcase
      // x1 mirror
      if (wbEn && (dec.rdId == regId_t'(1))) begin
        leds <= wbData[`LED_WIDTH-1:0];
      end
    end
  end

  // instruction register
  always_ff @(posedge CLK) begin
    if (state == stFetchInstr) begin
      instr <= fetchWord;
    end
  end

  stateLegal: assert property (
    @(posedge CLK) disable iff (!resetn)
    state inside {stFetchInstr, stFetchRegs, stExecute}
  ) else $error("coreControl illegal state");

  pcAligned: assert property (
    @(posedge CLK) disable iff (!resetn) pc[1:0] == 2'b00
  ) else $error("coreControl misaligned pc %h", pc);

  wbOnlyInExecute: assert property (
    @(posedge CLK) disable iff (!resetn) wbEn |-> (state == stExecute)
  ) else $error("coreControl write-back outside execute");

endmodule

//--- source/executeUnit.sv
`timescale 1ns/10ps
`include "rvCore_cfg.svh"

module executeUnit
  import rvCorePkg::*;
(
  input  decodedInstr_t dec,
  input  word_t rs1Val,
  input  word_t rs2Val,
  input  word_t pc,
  output word_t nextPc,
  output word_t wbData
);

  word_t aluIn2;
  word_t aluOut;
  word_t pcPlus4;
  logic [$clog2(`XLEN)-1:0] shamt;
  logic cond; // raw comparator result
  logic taken;

  // operand b and shift amount, reg or imm form
  // imm shamt sits in the rs2 field bits
  assign aluIn2 = dec.isAluReg ? rs2Val : dec.iImm;
  assign shamt  = dec.isAluReg ? rs2Val[$clog2(`XLEN)-1:0] : dec.iImm[$clog2(`XLEN)-1:0];

  always_comb begin
    case (dec.funct3)
      3'b000: begin
        // addi has no sub, altOp bit there is part of the immediate
        if (dec.isAluReg && dec.altOp) begin
          aluOut = rs1Val - aluIn2;
        end else begin
          aluOut = rs1Val + aluIn2;
        end
      end
      3'b001: aluOut = rs1Val << shamt;
      3'b010: aluOut = word_t'($signed(rs1Val) < $signed(aluIn2)); // slt
      3'b011: aluOut = word_t'(rs1Val < aluIn2); // sltu
      3'b100: aluOut = rs1Val ^ aluIn2;
      3'b101: begin
        if (dec.altOp) begin
          aluOut = word_t'($signed(rs1Val) >>> shamt); // sra, sign fill
        end else begin
          aluOut = rs1Val >> shamt;
        end
      end
      3'b110: aluOut = rs1Val | aluIn2;
      default: aluOut = rs1Val & aluIn2; // 3'b111
    endcase
  end

  // branch comparator, always on rs2 not the immediate
  always_comb begin
    case (dec.funct3)
      3'b000: cond = (rs1Val == rs2Val); // beq
      3'b001: cond = (rs1Val != rs2Val); // bne
      3'b100: cond = ($signed(rs1Val) < $signed(rs2Val));
      3'b101: cond = ($signed(rs1Val) >= $signed(rs2Val));
      3'b110: cond = (rs1Val < rs2Val); // bltu
      3'b111: cond = (rs1Val >= rs2Val); // bgeu
      default: cond = 1'b0; // 010 / 011 not branches
    endcase
  end

  assign taken   = dec.isBranch && cond;
  assign pcPlus4 = pc + word_t'(4);

  // next pc, taken branch first
  always_comb begin
    if (taken) begin
      nextPc = pc + dec.bImm;
    end else if (dec.isJal) begin
      nextPc = pc + dec.jImm;
    end else if (dec.isJalr) begin
      nextPc = (rs1Val + dec.iImm) & ~word_t'(1); // lsb dropped per spec
    end else begin
      nextPc = pcPlus4;
    end
  end

  // write-back source
  always_comb begin
    if (dec.isJal || dec.isJalr) begin
      wbData = pcPlus4; // link address
    end else if (dec.isLui) begin
      wbData = dec.uImm;
    end else if (dec.isAuipc) begin
      wbData = pc + dec.uImm;
    end else begin
      wbData = aluOut;
    end
  end

endmodule

//--- source/regFile.sv
`timescale 1ns/10ps
`include "rvCore_cfg.svh"

module regFile
  import rvCorePkg::*;
(
  input  logic CLK,
  input  logic resetn,
  input  logic readEn, // one cycle in stFetchRegs
  input  regId_t rs1Id,
  input  regId_t rs2Id,
  input  regId_t rdId,
  input  logic wbEn,
  input  word_t wbData,
  output word_t rs1Val,
  output word_t rs2Val
);

  word_t regs [`REG_COUNT];

  // write port, x0 never written
  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEn && (rdId != '0)) begin
      regs[rdId] <= wbData;
    end
  end

  // operand latches, held through stExecute
  always_ff @(posedge CLK) begin
    if (readEn) begin
      rs1Val <= regs[rs1Id];
      rs2Val <= regs[rs2Id];
    end
  end

  // x0 must read back as zero on both ports
  x0ReadsZero: assert property (
    @(posedge CLK) disable iff (!resetn)
    readEn |=> (($past(rs1Id) != '0) || (rs1Val == '0)) &&
               (($past(rs2Id) != '0) || (rs2Val == '0))
  ) else $error("regFile x0 read nonzero");

endmodule

//--- source/instrDecoder.sv
`timescale 1ns/10ps
`include "rvCore_cfg.svh"

module instrDecoder
  import rvCorePkg::*;
(
  input  instrWord_t instr,
  output decodedInstr_t dec
);

  logic [6:0] opcode;

  assign opcode = instr.rFmt.opcode; // same bits in every view

  // opcode class flags
  assign dec.isAluReg = (opcode == opAluReg);
  assign dec.isAluImm = (opcode == opAluImm);
  assign dec.isBranch = (opcode == opBranch);
  assign dec.isJal    = (opcode == opJal);
  assign dec.isJalr   = (opcode == opJalr);
  assign dec.isAuipc  = (opcode == opAuipc);
  assign dec.isLui    = (opcode == opLui);

  // register ids from the R view
  assign dec.rs1Id = instr.rFmt.rs1;
  assign dec.rs2Id = instr.rFmt.rs2;
  assign dec.rdId  = instr.rFmt.rd;

  assign dec.funct3 = instr.rFmt.funct3;
  assign dec.altOp  = instr.rFmt.funct7[5]; // also imm[10] for srai

  // I-immediate, sign extended from bit 11
  assign dec.iImm = {{(`XLEN-12){instr.iFmt.imm[11]}}, instr.iFmt.imm};

  // B-immediate, scattered bits, always even
  assign dec.bImm = {
    {(`XLEN-13){instr.bFmt.immSign}},
    instr.bFmt.immSign,
    instr.bFmt.imm11,
    instr.bFmt.immHi,
    instr.bFmt.immLo,
    1'b0
  };

  // U-immediate, upper 20 bits, low 12 zero
  assign dec.uImm = {instr.uFmt.imm, 12'b0};

  // J-immediate, +-1 MiB range
  assign dec.jImm = {
    {(`XLEN-21){instr.jFmt.immSign}},
    instr.jFmt.immSign,
    instr.jFmt.immHi,
    instr.jFmt.imm11,
    instr.jFmt.immLo,
    1'b0
  };

endmodule

//--- source/instrMem.sv
`timescale 1ns/10ps
`include "rvCore_cfg.svh"

module instrMem
  import rvCorePkg::*;
(
  input  logic CLK,
  input  logic progWe, // load strobe, used under reset
  input  logic [`IMEM_ADDR_WIDTH-1:0] progAddr,
  input  instrWord_t progData,
  input  logic [`IMEM_ADDR_WIDTH-1:0] fetchAddr,
  output instrWord_t fetchWord
);

  instrWord_t mem [`IMEM_DEPTH]; // block ram, no init

  // load port
  always_ff @(posedge CLK) begin
    if (progWe) begin
      mem[progAddr] <= progData;
    end
  end

  // read every edge
  // control picks the word up only in stFetchInstr
  always_ff @(posedge CLK) begin
    fetchWord <= mem[fetchAddr];
  end

  // an unknown load address would corrupt an unknown word
  progAddrKnown: assert property (
    @(posedge CLK) progWe |-> !$isunknown(progAddr)
  ) else $error("instrMem load with unknown address");

endmodule

//--- source/rvCorePkg.sv
`include "rvCore_cfg.svh"

package rvCorePkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_ID_WIDTH-1:0] regId_t;
  typedef logic [`LED_WIDTH-1:0] ledWord_t;

  // major opcodes still executed
  typedef enum logic [6:0] {
    opAluReg = 7'b0110011, // rd <- rs1 op rs2
    opAluImm = 7'b0010011, // rd <- rs1 op iImm
    opBranch = 7'b1100011,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opAuipc  = 7'b0010111,
    opLui    = 7'b0110111
  } opcode_e;

  // per-format field views, msb first
  typedef struct packed {
    logic [6:0] funct7;
    regId_t rs2;
    regId_t rs1;
    logic [2:0] funct3;
    regId_t rd;
    logic [6:0] opcode;
  } rFmt_t;

  typedef struct packed {
    logic [11:0] imm;
    regId_t rs1;
    logic [2:0] funct3;
    regId_t rd;
    logic [6:0] opcode;
  } iFmt_t;

  typedef struct packed {
    logic immSign; // imm[12]
    logic [5:0] immHi; // imm[10:5]
    regId_t rs2;
    regId_t rs1;
    logic [2:0] funct3;
    logic [3:0] immLo; // imm[4:1]
    logic imm11;
    logic [6:0] opcode;
  } bFmt_t;

  typedef struct packed {
    logic [19:0] imm; // imm[31:12]
    regId_t rd;
    logic [6:0] opcode;
  } uFmt_t;

  typedef struct packed {
    logic immSign; // imm[20]
    logic [9:0] immLo; // imm[10:1]
    logic imm11;
    logic [7:0] immHi; // imm[19:12]
    regId_t rd;
    logic [6:0] opcode;
  } jFmt_t;

  // one instruction word, five decodings
  typedef union packed {
    rFmt_t rFmt;
    iFmt_t iFmt;
    bFmt_t bFmt;
    uFmt_t uFmt;
    jFmt_t jFmt;
  } instrWord_t;

  typedef struct packed {
    logic isAluReg;
    logic isAluImm;
    logic isBranch;
    logic isJal;
    logic isJalr;
    logic isAuipc;
    logic isLui;
    regId_t rs1Id;
    regId_t rs2Id;
    regId_t rdId;
    logic [2:0] funct3;
    logic altOp; // funct7[5], sub / sra select
    word_t iImm;
    word_t bImm;
    word_t uImm;
    word_t jImm;
  } decodedInstr_t;

  typedef enum logic [1:0] {
    stFetchInstr = 2'd0,
    stFetchRegs  = 2'd1,
    stExecute    = 2'd2
  } coreState_e;

endpackage

//--- include/rvCore_cfg.svh
`ifndef RVCORE_CFG_SVH
`define RVCORE_CFG_SVH

// datapath and instruction word width
`define XLEN 32

// architectural register file
`define REG_COUNT 32
`define REG_ID_WIDTH 5

// instruction memory, word addressed
`define IMEM_DEPTH 256
`define IMEM_ADDR_WIDTH 8

`define LED_WIDTH 5 // mirrors low bits of x1
`define RESET_PC 0 // first fetch address

`endif
